// ==== Bender.yml ====
package:
  name: rv32i_pipeline

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/rv32i_types.sv
      - hw/cpu_control.sv
      - hw/regfile.sv
      - hw/alu_cmp.sv
      - hw/hazard_unit.sv
      - hw/cpu_datapath.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/cpu_properties.sv
      - bench/cpu_tb.sv

// ==== bench/cpu_golden.txt ====
# I <addr> <instr>   D <addr> <data>   T <num> <name> <stores>
# S <address_b> <wdata> <wmask>, all in hex
I 000 20000513
I 004 06400093
I 008 ff900113
I 00c 002081b3
I 010 00352023
I 014 40208233
I 018 00452223
I 01c 0020c2b3
I 020 00552423
I 024 0020e333
I 028 00652623
I 02c 0020f3b3
I 030 00752823
I 034 00112433
I 038 00852a23
I 03c 001114b3
I 040 00952c23
I 044 001155b3
I 048 00b52e23
I 04c 40115633
I 050 02c52023
I 054 abcde6b7
I 058 02d52223
I 05c 02252423
I 060 00500713
I 064 00e707b3
I 068 00e78833
I 06c 03052623
I 070 02f52823
I 074 04050893
I 078 00e8a023
I 07c 10052903
I 080 001909b3
I 084 03352a23
I 088 10452a03
I 08c 03452c23
I 090 00e70663
I 094 02152e23
I 098 02252e23
I 09c 00e71463
I 0a0 03052e23
I 0a4 00c00aef
I 0a8 02152e23
I 0ac 02252e23
I 0b0 05552223
I 0b4 04150823
I 0b8 04e508a3
I 0bc 05050923
I 0c0 042509a3
I 0c4 05052b83
I 0c8 05752423
I 0cc 0000006f
D 300 11111111
D 304 22220000
D 250 a5a5a5a5
T 1 alu_ops 11
S 200 0000005d f
S 204 0000006b f
S 208 ffffff9d f
S 20c fffffffd f
S 210 00000060 f
S 214 00000001 f
S 218 ffffff90 f
S 21c 0fffffff f
S 220 ffffffff f
S 224 abcde000 f
S 228 fffffff9 f
T 2 forwarding 3
S 22c 0000000f f
S 230 0000000a f
S 240 00000005 f
T 3 load_use 2
S 234 11111175 f
S 238 22220000 f
T 4 control_flow 2
S 23c 0000000f f
S 244 000000a8 f
T 5 byte_stores 5
S 250 00000064 1
S 251 00000500 2
S 252 000f0000 4
S 253 f9000000 8
S 248 f90f0564 f

// ==== bench/cpu_properties.sv ====
`timescale 1ns/1ps

module cpu_properties (
	input logic clk,
	input logic rst_n,
	input logic read_a,
	input logic resp_a,
	input logic [31:0] address_a,
	input logic read_b,
	input logic write,
	input logic resp_b,
	input logic [31:0] address_b,
	input logic [31:0] wdata,
	input logic [3:0] wmask
);

	// request held until its resp
	assert property (@(posedge clk) disable iff (!rst_n)
		((read_b || write) && !resp_b) |=> ($stable(address_b) && $stable(wdata)
		&& $stable(wmask) && $stable(write) && $stable(read_b)))
		else $error("data request changed before its response");

	assert property (@(posedge clk) disable iff (!rst_n)
		(read_a && !resp_a) |=> ($stable(address_a) && read_a))
		else $error("fetch request changed before its response");

	assert property (@(posedge clk) disable iff (!rst_n) !(read_b && write))
		else $error("read_b and write high together");

	assert property (@(posedge clk) $rose(rst_n) |-> (!read_b && !write))
		else $error("data port active right after reset");

endmodule

bind cpu_datapath cpu_properties props (
	.clk(clk),
	.rst_n(rst_n),
	.read_a(read_a),
	.resp_a(resp_a),
	.address_a(address_a),
	.read_b(read_b),
	.write(write),
	.resp_b(resp_b),
	.address_b(address_b),
	.wdata(wdata),
	.wmask(wmask)
);

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module cpu_tb;

	logic clk;
	logic rst_n;
	logic resp_a;
	logic resp_b;
	logic [31:0] rdata_a;
	logic [31:0] rdata_b;
	logic read_a;
	logic read_b;
	logic write;
	logic [3:0] wmask;
	logic [31:0] address_a;
	logic [31:0] address_b;
	logic [31:0] wdata;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];

	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [3:0] exp_mask [$];
	int store_test [$];
	string test_name [$];
	int test_num [$];
	int test_left [$];
	int test_err [$];

	logic [31:0] lfsr;
	int errors;
	int checked;
	int tests_passed;
	int tests_failed;
	int limit;
	bit loaded;
	bit golden_ok;
	bit first_fetch;
	bit mism;
	bit a_wait;
	bit b_wait;
	logic [1:0] a_cnt;
	logic [1:0] b_cnt;

	cpu_datapath uut (
		.clk,
		.rst_n,
		.resp_a,
		.resp_b,
		.rdata_a,
		.rdata_b,
		.read_a,
		.read_b,
		.write,
		.wmask,
		.address_a,
		.address_b,
		.wdata
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// taps 32 22 2 1
	function logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function logic [1:0] delay_pick();
		logic [1:0] d;
		d[0] = lfsr_bit();
		d[1] = lfsr_bit();
		return d;
	endfunction

	task check_addr(input string sig, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("ERR t=%0t %s expected %h got %h", $time, sig, exp, act);
			errors++;
			mism = 1'b1;
		end
	endtask

	task check_data(input string sig, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("ERR t=%0t %s expected %h got %h", $time, sig, exp, act);
			errors++;
			mism = 1'b1;
		end
	endtask

	task check_mask(input string sig, input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp) begin
			$display("ERR t=%0t %s expected %h got %h", $time, sig, exp, act);
			errors++;
			mism = 1'b1;
		end
	endtask

	task check_store(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] mask);
		int t;
		if (checked >= exp_addr.size()) begin
			$display("unexpected store to %h at %0t after the last expected store", addr, $time);
			errors++;
			return;
		end
		mism = 1'b0;
		check_addr("address_b", exp_addr[checked], addr);
		check_data("wdata", exp_data[checked], data);
		check_mask("wmask", exp_mask[checked], mask);
		t = store_test[checked];
		if (mism) test_err[t]++;
		test_left[t]--;
		checked++;
		if (test_left[t] == 0) begin  // last store of this test
			if (test_err[t] == 0) begin
				$display("test %0d %s: ok", test_num[t], test_name[t]);
				tests_passed++;
			end else begin
				$display("test %0d %s: %0d bad stores", test_num[t], test_name[t],
					test_err[t]);
				tests_failed++;
			end
		end
	endtask

	task load_golden(output bit ok);
		int fd;
		int n;
		int num;
		int cnt;
		string line;
		string name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen("bench/cpu_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/cpu_golden.txt");
			ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n == 0 || line.len() < 2) continue;
				case (line.getc(0))
					"I": begin
						n = $sscanf(line, "I %h %h", a, b);
						imem[a[9:2]] = b;
					end
					"D": begin
						n = $sscanf(line, "D %h %h", a, b);
						dmem[a[9:2]] = b;
					end
					"T": begin
						n = $sscanf(line, "T %d %s %d", num, name, cnt);
						test_num.push_back(num);
						test_name.push_back(name);
						test_left.push_back(cnt);
						test_err.push_back(0);
					end
					"S": begin
						n = $sscanf(line, "S %h %h %h", a, b, c);
						exp_addr.push_back(a);
						exp_data.push_back(b);
						exp_mask.push_back(c[3:0]);
						store_test.push_back(test_name.size() - 1);
					end
					default: ;  // comment line
				endcase
			end
			$fclose(fd);
			ok = 1'b1;
		end
	endtask

	// both memory ports in one process so the lfsr order is fixed
	always @(negedge clk) begin
		if (!rst_n) begin
			resp_a = 1'b0;
			resp_b = 1'b0;
			a_wait = 1'b0;
			b_wait = 1'b0;
		end else begin
			resp_a = 1'b0;
			if (read_a) begin
				if (!a_wait) begin
					a_cnt = delay_pick();
					a_wait = 1'b1;
					if (first_fetch) begin
						check_addr("address_a", `RV_RESET_PC, address_a);
						first_fetch = 1'b0;
					end
				end
				if (a_cnt == 2'd0) begin
					resp_a = 1'b1;
					rdata_a = imem[address_a[9:2]];
					a_wait = 1'b0;
				end else begin
					a_cnt--;
				end
			end
			resp_b = 1'b0;
			if (read_b || write) begin
				if (!b_wait) begin
					b_cnt = delay_pick();
					b_wait = 1'b1;
				end
				if (b_cnt == 2'd0) begin
					resp_b = 1'b1;
					b_wait = 1'b0;
					if (write) begin
						for (int k = 0; k < 4; k++) begin
							if (wmask[k]) dmem[address_b[9:2]][8*k +: 8] = wdata[8*k +: 8];
						end
						check_store(address_b, wdata, wmask);
					end else begin
						rdata_b = dmem[address_b[9:2]];
					end
				end else begin
					b_cnt--;
				end
			end
		end
	end

	initial begin
		wait (loaded);
		repeat (limit) @(posedge clk);
		$display("run timed out after %0d cycles, %0d of %0d stores seen",
			limit, checked, exp_addr.size());
		$display("Test failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		resp_a = 1'b0;
		resp_b = 1'b0;
		rdata_a = 32'd0;
		rdata_b = 32'd0;
		lfsr = 32'h6b8c91f5;
		errors = 0;
		checked = 0;
		tests_passed = 0;
		tests_failed = 0;
		first_fetch = 1'b1;
		for (int i = 0; i < 256; i++) begin
			imem[i] = `RV_NOP | (32'(i) << 20);  // addi x0 with the index as imm
			dmem[i] = {~16'(i), 16'(i)};
		end
		load_golden(golden_ok);
		if (!golden_ok) begin
			$display("Test failed");
			$finish;
		end else begin
			limit = 40 * exp_addr.size() + 200;
			loaded = 1'b1;
			repeat (4) @(negedge clk);
			rst_n = 1'b1;
			wait (checked == exp_addr.size());
			repeat (50) @(negedge clk);  // catch stray stores from the final loop
			$display("%0d tests passed, %0d tests failed, %0d errors",
				tests_passed, tests_failed, errors);
			if (errors == 0 && tests_failed == 0) begin
				$display("Test passed");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

endmodule

// ==== hw/alu_cmp.sv ====
`timescale 1ns/1ps

module alu_cmp (
	input rv32i_types::idex_t stage,
	input logic [31:0] op_a,
	input logic [31:0] op_b_reg,
	output logic [31:0] result,
	output logic redirect,
	output logic [31:0] target
);

	logic [31:0] a;
	logic [31:0] b;
	logic [4:0] shamt;
	logic taken;

	assign a = stage.cword.alu_a_pc ? stage.pc : op_a;
	assign b = stage.cword.alu_b_imm ? stage.imm : op_b_reg;
	assign shamt = b[4:0];

	always_comb begin
		case (stage.cword.aluop)
			rv32i_types::alu_add:  result = stage.cword.alu_alt ? a - b : a + b;
			rv32i_types::alu_sll:  result = a << shamt;
			rv32i_types::alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
			rv32i_types::alu_sltu: result = {31'd0, a < b};
			rv32i_types::alu_xor:  result = a ^ b;
			rv32i_types::alu_srl: begin
				if (stage.cword.alu_alt) begin
					result = $signed(a) >>> shamt;  // sra keeps the sign
				end else begin
					result = a >> shamt;
				end
			end
			rv32i_types::alu_or:   result = a | b;
			default:               result = a & b;
		endcase
	end

	// comparator always looks at the forwarded register pair
	always_comb begin
		case (rv32i_types::branch_funct3'(stage.cword.funct3))
			rv32i_types::beq: taken = (op_a == op_b_reg);
			rv32i_types::bne: taken = (op_a != op_b_reg);
			default:          taken = 1'b0;
		endcase
	end

	assign redirect = (stage.cword.opcode == rv32i_types::op_jal) ||
		((stage.cword.opcode == rv32i_types::op_br) && taken);
	assign target = result;  // pc + imm for br and jal
endmodule

// ==== hw/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
	input rv32i_types::rv32i_instr_t instr,
	output rv32i_types::rv32i_control_word cword,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [31:0] imm
);

	always_comb begin
		cword = '0;
		cword.opcode = rv32i_types::rv32i_opcode'(instr.r.opcode);
		cword.aluop = rv32i_types::alu_add;
		cword.funct3 = instr.r.funct3;
		cword.rd = instr.r.rd;
		cword.wb_sel = rv32i_types::wb_alu;
		rs1 = 5'd0;  // unused sources stay x0, no false hazards
		rs2 = 5'd0;
		imm = 32'd0;

		case (cword.opcode)
			rv32i_types::op_lui: begin
				cword.load_regfile = 1'b1;
				cword.alu_b_imm = 1'b1;  // x0 + imm
				imm = {instr.u.imm, 12'b0};
			end
			rv32i_types::op_jal: begin
				cword.load_regfile = 1'b1;
				cword.alu_a_pc = 1'b1;   // alu forms the target
				cword.alu_b_imm = 1'b1;
				cword.wb_sel = rv32i_types::wb_pc4;
				imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
					instr.j.imm11, instr.j.imm10_1, 1'b0};
			end
			rv32i_types::op_br: begin
				cword.rd = 5'd0;
				cword.alu_a_pc = 1'b1;
				cword.alu_b_imm = 1'b1;
				rs1 = instr.b.rs1;
				rs2 = instr.b.rs2;
				imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
					instr.b.imm10_5, instr.b.imm4_1, 1'b0};
			end
			rv32i_types::op_load: begin
				cword.load_regfile = 1'b1;
				cword.mem_read = 1'b1;
				cword.alu_b_imm = 1'b1;
				cword.wb_sel = rv32i_types::wb_mem;
				rs1 = instr.i.rs1;
				imm = {{20{instr.i.imm[11]}}, instr.i.imm};
			end
			rv32i_types::op_store: begin
				cword.rd = 5'd0;
				cword.mem_write = 1'b1;
				cword.alu_b_imm = 1'b1;
				rs1 = instr.s.rs1;
				rs2 = instr.s.rs2;
				imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
			end
			rv32i_types::op_imm: begin
				cword.load_regfile = 1'b1;
				cword.alu_b_imm = 1'b1;
				cword.aluop = rv32i_types::alu_ops'(instr.i.funct3);
				// only srai carries funct7 in the immediate
				cword.alu_alt = (instr.i.funct3 == 3'b101) && instr.r.funct7[5];
				rs1 = instr.i.rs1;
				imm = {{20{instr.i.imm[11]}}, instr.i.imm};
			end
			rv32i_types::op_reg: begin
				cword.load_regfile = 1'b1;
				cword.aluop = rv32i_types::alu_ops'(instr.r.funct3);
				cword.alu_alt = instr.r.funct7[5];
				rs1 = instr.r.rs1;
				rs2 = instr.r.rs2;
			end
			default: cword.rd = 5'd0;  // unsupported, all enables low
		endcase
	end

endmodule

// ==== hw/cpu_datapath.sv ====
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module cpu_datapath (
	input logic clk,
	input logic rst_n,
	input logic resp_a,
	input logic resp_b,
	input logic [31:0] rdata_a,
	input logic [31:0] rdata_b,
	output logic read_a,
	output logic read_b,
	output logic write,
	output logic [3:0] wmask,
	output logic [31:0] address_a,
	output logic [31:0] address_b,
	output logic [31:0] wdata
);

	logic [31:0] pc;
	logic run;
	logic a_done;
	logic b_done;
	logic [31:0] a_buf;
	logic [31:0] b_buf;
	logic b_req;
	logic stall;
	logic [31:0] fetch_word;
	logic [31:0] load_word;

	rv32i_types::ifid_t ifid;
	rv32i_types::idex_t idex;
	rv32i_types::exmem_t exmem;
	rv32i_types::memwb_t memwb;

	rv32i_types::rv32i_control_word id_cword;
	logic [4:0] id_rs1;
	logic [4:0] id_rs2;
	logic [31:0] id_imm;
	logic [31:0] id_rs1_val;
	logic [31:0] id_rs2_val;

	rv32i_types::fwd_sel_t fwd_a;
	rv32i_types::fwd_sel_t fwd_b;
	logic load_use;
	logic redirect;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] ex_result;
	logic [31:0] ex_target;
	logic [31:0] exmem_fwd;
	logic [31:0] wb_value;
	logic [1:0] byte_off;

	// memory handshakes and the global stall
	assign address_a = pc;
	assign read_a = run & ~a_done;
	assign fetch_word = a_done ? a_buf : rdata_a;

	assign b_req = exmem.cword.mem_read | exmem.cword.mem_write;
	assign read_b = exmem.cword.mem_read & ~b_done;
	assign write = exmem.cword.mem_write & ~b_done;
	assign load_word = b_done ? b_buf : rdata_b;

	assign stall = ~run | ~(resp_a | a_done) | (b_req & ~(resp_b | b_done));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			a_done <= 1'b0;
			b_done <= 1'b0;
		end else begin
			run <= 1'b1;
			if (!stall) begin
				a_done <= 1'b0;
				b_done <= 1'b0;
			end else begin
				// one port answered, the other is still out
				if (resp_a) a_done <= 1'b1;
				if (resp_b) b_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resp_a && !a_done) a_buf <= rdata_a;
		if (resp_b && !b_done) b_buf <= rdata_b;
	end

	// fetch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `RV_RESET_PC;
			ifid.instr <= `RV_NOP;
			ifid.pc <= `RV_RESET_PC;
		end else if (!stall) begin
			if (redirect) begin
				pc <= ex_target;
				ifid.instr <= `RV_NOP;  // squash the wrong-path fetch
			end else if (!load_use) begin
				pc <= pc + 32'd4;
				ifid.instr <= fetch_word;
				ifid.pc <= pc;
			end
		end
	end

	// decode
	cpu_control ctrl (
		.instr(ifid.instr),
		.cword(id_cword),
		.rs1(id_rs1),
		.rs2(id_rs2),
		.imm(id_imm)
	);

	regfile regs (
		.clk,
		.rst_n,
		.load(memwb.cword.load_regfile & ~stall),
		.dest(memwb.cword.rd),
		.src_a(id_rs1),
		.src_b(id_rs2),
		.in(wb_value),
		.reg_a(id_rs1_val),
		.reg_b(id_rs2_val)
	);

	hazard_unit hazard (
		.idex_rs1(idex.rs1),
		.idex_rs2(idex.rs2),
		.id_rs1,
		.id_rs2,
		.idex(idex.cword),
		.exmem(exmem.cword),
		.memwb(memwb.cword),
		.fwd_a,
		.fwd_b,
		.load_use
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idex <= '0;
		end else if (!stall) begin
			if (redirect || load_use) begin
				idex <= '0;  // bubble, every enable low
			end else begin
				idex <= '{cword: id_cword, pc: ifid.pc, pc4: ifid.pc + 32'd4,
					rs1: id_rs1, rs2: id_rs2, rs1_val: id_rs1_val,
					rs2_val: id_rs2_val, imm: id_imm};
			end
		end
	end

	// execute
	assign exmem_fwd = (exmem.cword.wb_sel == rv32i_types::wb_pc4) ? exmem.pc4
		: exmem.alu_result;

	always_comb begin
		case (fwd_a)
			rv32i_types::fwd_exmem: op_a = exmem_fwd;
			rv32i_types::fwd_memwb: op_a = wb_value;
			default:                op_a = idex.rs1_val;
		endcase
		case (fwd_b)
			rv32i_types::fwd_exmem: op_b = exmem_fwd;
			rv32i_types::fwd_memwb: op_b = wb_value;
			default:                op_b = idex.rs2_val;
		endcase
	end

	alu_cmp ex (
		.stage(idex),
		.op_a,
		.op_b_reg(op_b),
		.result(ex_result),
		.redirect,
		.target(ex_target)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exmem <= '0;
		end else if (!stall) begin
			exmem <= '{cword: idex.cword, alu_result: ex_result, store_data: op_b,
				pc4: idex.pc4};
		end
	end

	// memory, sb lands on its byte lane
	assign address_b = exmem.alu_result;
	assign byte_off = exmem.alu_result[1:0];

	always_comb begin
		if (exmem.cword.funct3 == 3'b000) begin
			wdata = exmem.store_data << {byte_off, 3'b000};
			wmask = 4'b0001 << byte_off;
		end else begin
			wdata = exmem.store_data;
			wmask = 4'b1111;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			memwb <= '0;
		end else if (!stall) begin
			memwb <= '{cword: exmem.cword, alu_result: exmem.alu_result,
				load_data: load_word, pc4: exmem.pc4};
		end
	end

	// writeback
	always_comb begin
		case (memwb.cword.wb_sel)
			rv32i_types::wb_mem: wb_value = memwb.load_data;
			rv32i_types::wb_pc4: wb_value = memwb.pc4;
			default:             wb_value = memwb.alu_result;
		endcase
	end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module hazard_unit #(
	parameter int IDX_W = $clog2(`RV_NREGS)
) (
	input logic [IDX_W-1:0] idex_rs1,
	input logic [IDX_W-1:0] idex_rs2,
	input logic [IDX_W-1:0] id_rs1,
	input logic [IDX_W-1:0] id_rs2,
	input rv32i_types::rv32i_control_word idex,
	input rv32i_types::rv32i_control_word exmem,
	input rv32i_types::rv32i_control_word memwb,
	output rv32i_types::fwd_sel_t fwd_a,
	output rv32i_types::fwd_sel_t fwd_b,
	output logic load_use
);

	// younger producer wins
	function automatic rv32i_types::fwd_sel_t pick(input logic [IDX_W-1:0] src);
		if (src == '0) begin
			return rv32i_types::fwd_none;
		end
		if (exmem.load_regfile && exmem.rd == src) begin
			return rv32i_types::fwd_exmem;
		end
		if (memwb.load_regfile && memwb.rd == src) begin
			return rv32i_types::fwd_memwb;
		end
		return rv32i_types::fwd_none;
	endfunction

	always_comb begin
		fwd_a = pick(idex_rs1);
		fwd_b = pick(idex_rs2);
	end

	// load data only exists after MEM, so the consumer waits one cycle
	assign load_use = idex.mem_read && (idex.rd != '0) &&
		((idex.rd == id_rs1) || (idex.rd == id_rs2));

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module regfile (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic [4:0] dest,
	input logic [4:0] src_a,
	input logic [4:0] src_b,
	input logic [31:0] in,
	output logic [31:0] reg_a,
	output logic [31:0] reg_b
);

	logic [31:0] regs [`RV_NREGS];
	logic wr_en;

	assign wr_en = load && (dest != 5'd0);  // x0 is hardwired

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wr_en) begin
			regs[dest] <= in;
		end
	end

	// writeback value visible to decode in the same cycle
	assign reg_a = (wr_en && dest == src_a) ? in : regs[src_a];
	assign reg_b = (wr_en && dest == src_b) ? in : regs[src_b];

endmodule

// ==== hw/rv32i_types.sv ====
package rv32i_types;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_jal   = 7'b1101111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	// encodings follow funct3 so op_reg/op_imm can cast directly
	typedef enum logic [2:0] {
		alu_add  = 3'b000, // sub with alu_alt
		alu_sll  = 3'b001,
		alu_slt  = 3'b010,
		alu_sltu = 3'b011,
		alu_xor  = 3'b100,
		alu_srl  = 3'b101, // sra with alu_alt
		alu_or   = 3'b110,
		alu_and  = 3'b111
	} alu_ops;

	typedef enum logic [2:0] {
		beq = 3'b000,
		bne = 3'b001
	} branch_funct3;

	typedef enum logic [1:0] {
		wb_alu = 2'b00,
		wb_mem = 2'b01,
		wb_pc4 = 2'b10
	} wb_sel_t;

	typedef enum logic [1:0] {
		fwd_none  = 2'b00,
		fwd_exmem = 2'b01,
		fwd_memwb = 2'b10
	} fwd_sel_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} rv32i_instr_t;

	typedef struct packed {
		rv32i_opcode opcode;
		alu_ops aluop;
		logic alu_alt;       // funct7 bit 5 for sub / sra
		logic [2:0] funct3;
		logic [4:0] rd;
		logic load_regfile;
		logic mem_read;
		logic mem_write;
		logic alu_b_imm;
		logic alu_a_pc;
		wb_sel_t wb_sel;
	} rv32i_control_word;

	typedef struct packed {
		rv32i_instr_t instr;
		logic [31:0] pc;
	} ifid_t;

	typedef struct packed {
		rv32i_control_word cword;
		logic [31:0] pc;
		logic [31:0] pc4;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [31:0] rs1_val;
		logic [31:0] rs2_val;
		logic [31:0] imm;
	} idex_t;

	typedef struct packed {
		rv32i_control_word cword;
		logic [31:0] alu_result;
		logic [31:0] store_data;
		logic [31:0] pc4;
	} exmem_t;

	typedef struct packed {
		rv32i_control_word cword;
		logic [31:0] alu_result;
		logic [31:0] load_data;
		logic [31:0] pc4;
	} memwb_t;

endpackage

// ==== include/rv32i_consts.svh ====
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

// architectural integer registers
`define RV_NREGS 32

`endif

// ==== src.f ====
+incdir+include
hw/rv32i_types.sv
hw/cpu_control.sv
hw/regfile.sv
hw/alu_cmp.sv
hw/hazard_unit.sv
hw/cpu_datapath.sv
bench/cpu_properties.sv
bench/cpu_tb.sv
